//--- src/axi_ram_pkg.sv
`default_nettype none

package axi_ram_pkg;

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 16;
    localparam int ID_W     = 4;
    localparam int BYTE_LSB = 2;              // byte offset bits inside a word
    localparam int STRB_W   = DATA_W / 8;
    localparam int WORD_W   = ADDR_W - BYTE_LSB;  // full-range word index

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [7:0]        len_t;         // beats minus one
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2,
        BURST_RSVD  = 2'd3   // treated as INCR
    } burst_e;

    // accepted AW or AR request
    typedef struct packed {
        id_t    id;
        addr_t  addr;
        len_t   len;
        burst_e burst;
    } burst_req_t;

    // RAM write port bundle
    typedef struct packed {
        logic              en;
        logic [WORD_W-1:0] waddr;
        data_t             data;
        strb_t             strb;
    } ram_wr_t;

endpackage

`default_nettype wire

//--- src/axi_burst_addr.sv
`default_nettype none

module axi_burst_addr
    import axi_ram_pkg::*;
(
    input  wire             S_AXI_ACLK,
    input  wire             S_AXI_ARESETN,
    input  wire             load,
    input  wire burst_req_t req,
    input  wire             step,
    output addr_t           addr,
    output logic            last
);

    addr_t  addr_q;
    len_t   len_q;
    burst_e burst_q;
    len_t   beat_cnt;

    addr_t  aligned;
    addr_t  incr_addr;
    addr_t  wrap_size;
    addr_t  wrap_mask;
    addr_t  next_addr;

    always_comb begin
        aligned   = {addr_q[ADDR_W-1:BYTE_LSB], {BYTE_LSB{1'b0}}};
        incr_addr = aligned + addr_t'(STRB_W);
        // wrap block is (len+1) words, aligned to its own size
        wrap_size = (addr_t'(len_q) + addr_t'(1)) << BYTE_LSB;
        wrap_mask = wrap_size - addr_t'(1);
        case (burst_q)
            BURST_FIXED: next_addr = addr_q;
            BURST_WRAP:  next_addr = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     next_addr = incr_addr;   // INCR and reserved
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            len_q    <= '0;
            burst_q  <= BURST_INCR;
            beat_cnt <= '0;
        end else if (load) begin
            len_q    <= req.len;
            burst_q  <= req.burst;
            beat_cnt <= '0;
        end else if (step) begin
            beat_cnt <= beat_cnt + len_t'(1);
        end
    end

    // current beat address
    always_ff @(posedge S_AXI_ACLK) begin
        if (load) begin
            addr_q <= req.addr;
        end else if (step) begin
            addr_q <= next_addr;
        end
    end

    assign addr = addr_q;
    assign last = (beat_cnt == len_q);

endmodule

`default_nettype wire

//--- src/axi_ram_write.sv
`default_nettype none

module axi_ram_write
    import axi_ram_pkg::*;
(
    input  wire             S_AXI_ACLK,
    input  wire             S_AXI_ARESETN,
    input  wire burst_req_t aw_req,
    input  wire             aw_valid,
    output logic            aw_ready,
    input  wire data_t      w_data,
    input  wire strb_t      w_strb,
    input  wire             w_last,
    input  wire             w_valid,
    output logic            w_ready,
    output id_t             b_id,
    output logic            b_valid,
    input  wire             b_ready,
    output ram_wr_t         ram_wr
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } write_state_e;

    write_state_e state;
    id_t          id_q;
    addr_t        gen_addr;
    logic         gen_last;
    logic         aw_hs;
    logic         w_hs;

    assign aw_ready = (state == W_IDLE);
    assign w_ready  = (state == W_DATA);
    assign b_valid  = (state == W_RESP);
    assign b_id     = id_q;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    axi_burst_addr i_axi_burst_addr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (aw_hs),
        .req           (aw_req),
        .step          (w_hs && !gen_last),   // hold on the final beat
        .addr          (gen_addr),
        .last          (gen_last)
    );

    // each accepted beat writes straight through to the RAM
    always_comb begin
        ram_wr.en    = w_hs;
        ram_wr.waddr = gen_addr[ADDR_W-1:BYTE_LSB];
        ram_wr.data  = w_data;
        ram_wr.strb  = w_strb;
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: if (aw_hs) state <= W_DATA;
                W_DATA: if (w_hs && w_last) state <= W_RESP;  // master's WLAST ends it
                W_RESP: if (b_ready) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            id_q <= aw_req.id;
        end
    end

endmodule

`default_nettype wire

//--- src/axi_ram_read.sv
`default_nettype none

module axi_ram_read
    import axi_ram_pkg::*;
(
    input  wire             S_AXI_ACLK,
    input  wire             S_AXI_ARESETN,
    input  wire burst_req_t ar_req,
    input  wire             ar_valid,
    output logic            ar_ready,
    output addr_t           ram_raddr,
    output logic            ram_ren,
    input  wire data_t      ram_rdata,
    output data_t           r_data,
    output id_t             r_id,
    output logic            r_last,
    output logic            r_valid,
    input  wire             r_ready
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ISSUE,   // RAM read enable
        R_WAIT,    // RAM data arriving
        R_HOLD     // beat on the bus
    } read_state_e;

    read_state_e state;
    id_t         id_q;
    data_t       data_q;
    logic        last_q;
    addr_t       gen_addr;
    logic        gen_last;
    logic        ar_hs;
    logic        r_hs;

    assign ar_ready = (state == R_IDLE);
    assign r_valid  = (state == R_HOLD);
    assign ar_hs    = ar_valid && ar_ready;
    assign r_hs     = r_valid && r_ready;

    axi_burst_addr i_axi_burst_addr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (ar_hs),
        .req           (ar_req),
        .step          (r_hs && !last_q),
        .addr          (gen_addr),
        .last          (gen_last)
    );

    assign ram_raddr = gen_addr;
    assign ram_ren   = (state == R_ISSUE);

    assign r_data = data_q;
    assign r_id   = id_q;
    assign r_last = last_q;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state  <= R_IDLE;
            last_q <= 1'b0;
        end else begin
            case (state)
                R_IDLE: if (ar_hs) state <= R_ISSUE;
                R_ISSUE: state <= R_WAIT;
                R_WAIT: begin
                    last_q <= gen_last;   // generator still on this beat
                    state  <= R_HOLD;
                end
                R_HOLD: begin
                    if (r_hs) begin
                        state <= last_q ? R_IDLE : R_ISSUE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // holding register for one beat
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            id_q <= ar_req.id;
        end
        if (state == R_WAIT) begin
            data_q <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- src/ram_pseudo_dual.sv
`default_nettype none

module ram_pseudo_dual
    import axi_ram_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 10
) (
    input  wire          S_AXI_ACLK,
    input  wire ram_wr_t wr,
    input  wire addr_t   raddr,
    input  wire          ren,
    output data_t        rdata
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    data_t mem [DEPTH];

    logic [MEM_ADDR_BITS-1:0] widx;
    logic [MEM_ADDR_BITS-1:0] ridx;

    // upper address bits drop, so addresses alias
    assign widx = wr.waddr[MEM_ADDR_BITS-1:0];
    assign ridx = raddr[BYTE_LSB +: MEM_ADDR_BITS];

    always_ff @(posedge S_AXI_ACLK) begin
        if (wr.en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.strb[b]) mem[widx][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
        if (ren) begin
            rdata <= mem[ridx];
        end
    end

endmodule

`default_nettype wire

//--- src/axi_ram_top.sv
`default_nettype none

module axi_ram_top
    import axi_ram_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 10
) (
    input  wire         S_AXI_ACLK,
    input  wire         S_AXI_ARESETN,

    input  wire id_t    S_AXI_AWID,
    input  wire addr_t  S_AXI_AWADDR,
    input  wire len_t   S_AXI_AWLEN,
    input  wire burst_e S_AXI_AWBURST,
    input  wire         S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,

    input  wire data_t  S_AXI_WDATA,
    input  wire strb_t  S_AXI_WSTRB,
    input  wire         S_AXI_WLAST,
    input  wire         S_AXI_WVALID,
    output logic        S_AXI_WREADY,

    output id_t         S_AXI_BID,
    output resp_t       S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  wire         S_AXI_BREADY,

    input  wire id_t    S_AXI_ARID,
    input  wire addr_t  S_AXI_ARADDR,
    input  wire len_t   S_AXI_ARLEN,
    input  wire burst_e S_AXI_ARBURST,
    input  wire         S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,

    output id_t         S_AXI_RID,
    output data_t       S_AXI_RDATA,
    output resp_t       S_AXI_RRESP,
    output logic        S_AXI_RLAST,
    output logic        S_AXI_RVALID,
    input  wire         S_AXI_RREADY
);

    burst_req_t aw_req;
    burst_req_t ar_req;
    ram_wr_t    ram_wr;
    addr_t      ram_raddr;
    logic       ram_ren;
    data_t      ram_rdata;

    assign aw_req = '{id: S_AXI_AWID, addr: S_AXI_AWADDR, len: S_AXI_AWLEN, burst: S_AXI_AWBURST};
    assign ar_req = '{id: S_AXI_ARID, addr: S_AXI_ARADDR, len: S_AXI_ARLEN, burst: S_AXI_ARBURST};

    // responses are always OKAY
    assign S_AXI_BRESP = RESP_OKAY;
    assign S_AXI_RRESP = RESP_OKAY;

    axi_ram_write i_axi_ram_write (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .aw_req        (aw_req),
        .aw_valid      (S_AXI_AWVALID),
        .aw_ready      (S_AXI_AWREADY),
        .w_data        (S_AXI_WDATA),
        .w_strb        (S_AXI_WSTRB),
        .w_last        (S_AXI_WLAST),
        .w_valid       (S_AXI_WVALID),
        .w_ready       (S_AXI_WREADY),
        .b_id          (S_AXI_BID),
        .b_valid       (S_AXI_BVALID),
        .b_ready       (S_AXI_BREADY),
        .ram_wr        (ram_wr)
    );

    axi_ram_read i_axi_ram_read (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ar_req        (ar_req),
        .ar_valid      (S_AXI_ARVALID),
        .ar_ready      (S_AXI_ARREADY),
        .ram_raddr     (ram_raddr),
        .ram_ren       (ram_ren),
        .ram_rdata     (ram_rdata),
        .r_data        (S_AXI_RDATA),
        .r_id          (S_AXI_RID),
        .r_last        (S_AXI_RLAST),
        .r_valid       (S_AXI_RVALID),
        .r_ready       (S_AXI_RREADY)
    );

    ram_pseudo_dual #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) i_ram_pseudo_dual (
        .S_AXI_ACLK (S_AXI_ACLK),
        .wr         (ram_wr),
        .raddr      (ram_raddr),
        .ren        (ram_ren),
        .rdata      (ram_rdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_axi_ram_top.sv
`default_nettype none

module tb_axi_ram_top
    import axi_ram_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // six tests of at most about 40 beats at 3 cycles each plus a wide margin
    localparam int CYCLE_LIMIT = 6000;

    logic   S_AXI_ACLK;
    logic   S_AXI_ARESETN;
    id_t    aw_id, ar_id, b_id, r_id;
    addr_t  aw_addr, ar_addr;
    len_t   aw_len, ar_len;
    burst_e aw_burst, ar_burst;
    logic   aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic   ar_valid, ar_ready, r_last, r_valid, r_ready;
    data_t  w_data, r_data;
    strb_t  w_strb;
    resp_t  b_resp, r_resp;

    logic [7:0] shadow [4096];   // byte image of the 4 KiB RAM
    data_t      wbuf [16];
    strb_t      sbuf [16];
    data_t      rbuf [16];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    integer     seed;
    string      test_name;

    axi_ram_top i_axi_ram_top (
        .S_AXI_ACLK    (S_AXI_ACLK),    .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWID    (aw_id),         .S_AXI_AWADDR  (aw_addr),
        .S_AXI_AWLEN   (aw_len),        .S_AXI_AWBURST (aw_burst),
        .S_AXI_AWVALID (aw_valid),      .S_AXI_AWREADY (aw_ready),
        .S_AXI_WDATA   (w_data),        .S_AXI_WSTRB   (w_strb),
        .S_AXI_WLAST   (w_last),        .S_AXI_WVALID  (w_valid),
        .S_AXI_WREADY  (w_ready),       .S_AXI_BID     (b_id),
        .S_AXI_BRESP   (b_resp),        .S_AXI_BVALID  (b_valid),
        .S_AXI_BREADY  (b_ready),       .S_AXI_ARID    (ar_id),
        .S_AXI_ARADDR  (ar_addr),       .S_AXI_ARLEN   (ar_len),
        .S_AXI_ARBURST (ar_burst),      .S_AXI_ARVALID (ar_valid),
        .S_AXI_ARREADY (ar_ready),      .S_AXI_RID     (r_id),
        .S_AXI_RDATA   (r_data),        .S_AXI_RRESP   (r_resp),
        .S_AXI_RLAST   (r_last),        .S_AXI_RVALID  (r_valid),
        .S_AXI_RREADY  (r_ready)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    always @(posedge S_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no progress after %0d cycles, run stopped", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // byte address of one beat of a burst
    function automatic addr_t beat_addr(addr_t start, len_t len, burst_e burst, int beat);
        int base;
        int size;
        int blk;
        base = int'(start) & 32'hfffc;
        size = (int'(len) + 1) * 4;
        case (burst)
            BURST_FIXED: return start;
            BURST_WRAP: begin
                blk = base - (base % size);
                return addr_t'(blk + (base - blk + 4 * beat) % size);
            end
            default: return addr_t'(base + 4 * beat);
        endcase
    endfunction

    function automatic data_t shadow_word(addr_t a);
        data_t w;
        for (int b = 0; b < 4; b++) w[8*b +: 8] = shadow[((a & 16'hfffc) + b) & 16'h0fff];
        return w;
    endfunction

    task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                               input burst_e burst, input bit gaps);
        addr_t  a;
        integer rnd;
        logic   hs;
        @(posedge S_AXI_ACLK);
        aw_id <= id;
        aw_addr <= addr;
        aw_len <= len;
        aw_burst <= burst;
        aw_valid <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!aw_ready);
        aw_valid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            w_valid <= 1'b1;
            w_data <= wbuf[beat];
            w_strb <= sbuf[beat];
            w_last <= (beat == int'(len));
            do @(posedge S_AXI_ACLK); while (!w_ready);
            a = beat_addr(addr, len, burst, beat);
            for (int b = 0; b < 4; b++) begin
                if (sbuf[beat][b]) shadow[((a & 16'hfffc) + b) & 16'h0fff] = wbuf[beat][8*b +: 8];
            end
        end
        w_valid <= 1'b0;
        w_last <= 1'b0;
        rnd = $random(seed);
        b_ready <= gaps ? rnd[0] : 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
            hs = b_valid && b_ready;
            if (!hs) begin
                rnd = $random(seed);
                b_ready <= gaps ? rnd[0] : 1'b1;   // random stall on B
            end
        end while (!hs);
        check("BID", id, b_id);
        check("BRESP", 2'b00, b_resp);
        b_ready <= 1'b0;
        @(posedge S_AXI_ACLK);
        check("AWREADY after B", 1'b1, aw_ready);
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                              input burst_e burst, input bit gaps);
        integer rnd;
        logic   hs;
        @(posedge S_AXI_ACLK);
        ar_id <= id;
        ar_addr <= addr;
        ar_len <= len;
        ar_burst <= burst;
        ar_valid <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!ar_ready);
        ar_valid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            rnd = $random(seed);
            r_ready <= gaps ? rnd[0] : 1'b1;
            do begin
                @(posedge S_AXI_ACLK);
                hs = r_valid && r_ready;
                if (!hs) begin
                    rnd = $random(seed);
                    r_ready <= gaps ? rnd[0] : 1'b1;
                end
            end while (!hs);
            rbuf[beat] = r_data;
            check("RDATA", shadow_word(beat_addr(addr, len, burst, beat)), r_data);
            check("RLAST", beat == int'(len), r_last);
            check("RID", id, r_id);
            check("RRESP", 2'b00, r_resp);
        end
        r_ready <= 1'b0;
        @(posedge S_AXI_ACLK);
        check("ARREADY after RLAST", 1'b1, ar_ready);
        check("RVALID after RLAST", 1'b0, r_valid);   // no extra beat
    endtask

    task automatic single_beat();
        test_name = "single_beat";
        wbuf[0] = 32'hA5A5_1234;
        sbuf[0] = 4'hF;
        write_burst(4'd3, 16'h0040, 8'd0, BURST_INCR, 1'b0);
        read_burst(4'd9, 16'h0040, 8'd0, BURST_INCR, 1'b0);
        check("word", 32'hA5A5_1234, rbuf[0]);
    endtask

    task automatic incr_burst();
        test_name = "incr_burst";
        for (int i = 0; i < 8; i++) begin
            wbuf[i] = 32'h1000_0000 + 32'h0101 * i;
            sbuf[i] = 4'hF;
        end
        write_burst(4'd1, 16'h0200, 8'd7, BURST_INCR, 1'b0);
        read_burst(4'd2, 16'h0200, 8'd7, BURST_INCR, 1'b0);
    endtask

    task automatic byte_strobes();
        test_name = "byte_strobes";
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 32'hA0A0_A0A0 ^ i;
            sbuf[i] = 4'hF;
        end
        write_burst(4'd4, 16'h0300, 8'd3, BURST_INCR, 1'b0);
        for (int i = 0; i < 4; i++) wbuf[i] = 32'h5B5B_5B5B + i;
        sbuf[0] = 4'b0001;
        sbuf[1] = 4'b0010;
        sbuf[2] = 4'b1100;
        sbuf[3] = 4'b0101;
        write_burst(4'd5, 16'h0300, 8'd3, BURST_INCR, 1'b0);
        read_burst(4'd6, 16'h0300, 8'd3, BURST_INCR, 1'b0);
    endtask

    task automatic fixed_burst();
        test_name = "fixed_burst";
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = 32'hC0DE_0000 + i;   // neighbors first
            sbuf[i] = 4'hF;
        end
        write_burst(4'd7, 16'h0400, 8'd2, BURST_INCR, 1'b0);
        for (int i = 0; i < 4; i++) wbuf[i] = 32'hF1F1_F100 + i;
        write_burst(4'd8, 16'h0404, 8'd3, BURST_FIXED, 1'b0);
        read_burst(4'd10, 16'h0400, 8'd2, BURST_INCR, 1'b0);
        check("left neighbor", 32'hC0DE_0000, rbuf[0]);
        check("fixed word", 32'hF1F1_F103, rbuf[1]);
        check("right neighbor", 32'hC0DE_0002, rbuf[2]);
        read_burst(4'd11, 16'h0404, 8'd3, BURST_FIXED, 1'b0);
        for (int i = 0; i < 4; i++) check("fixed repeat", 32'hF1F1_F103, rbuf[i]);
    endtask

    task automatic wrap_burst();
        test_name = "wrap_burst";
        wbuf[0] = 32'hAB00_0108;   // data tagged with its target address
        wbuf[1] = 32'hAB00_010C;
        wbuf[2] = 32'hAB00_0100;
        wbuf[3] = 32'hAB00_0104;
        for (int i = 0; i < 4; i++) sbuf[i] = 4'hF;
        write_burst(4'd12, 16'h0108, 8'd3, BURST_WRAP, 1'b0);
        read_burst(4'd13, 16'h0100, 8'd3, BURST_INCR, 1'b0);
        for (int i = 0; i < 4; i++) check("wrap placement", 32'hAB00_0100 + 4 * i, rbuf[i]);
    endtask

    task automatic back_pressure();
        test_name = "back_pressure";
        for (int i = 0; i < 16; i++) begin
            wbuf[i] = $random(seed);
            sbuf[i] = 4'hF;
        end
        write_burst(4'd14, 16'h0500, 8'd15, BURST_INCR, 1'b1);
        read_burst(4'd15, 16'h0500, 8'd15, BURST_INCR, 1'b1);
    endtask

    initial begin
        seed = 64827;
        S_AXI_ARESETN <= 1'b0;
        aw_id <= '0;
        aw_addr <= '0;
        aw_len <= '0;
        aw_burst <= BURST_INCR;
        aw_valid <= 1'b0;
        w_data <= '0;
        w_strb <= '0;
        w_last <= 1'b0;
        w_valid <= 1'b0;
        b_ready <= 1'b0;
        ar_id <= '0;
        ar_addr <= '0;
        ar_len <= '0;
        ar_burst <= BURST_INCR;
        ar_valid <= 1'b0;
        r_ready <= 1'b0;
        repeat (4) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge S_AXI_ACLK);
        single_beat();
        incr_burst();
        byte_strobes();
        fixed_burst();
        wrap_burst();
        back_pressure();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_ram_top.f
src/axi_ram_pkg.sv
src/axi_burst_addr.sv
src/axi_ram_write.sv
src/axi_ram_read.sv
src/ram_pseudo_dual.sv
src/axi_ram_top.sv
tb/tb_axi_ram_top.sv
